// ==== rv_core.f ====
+incdir+testbench
hw/rv_pkg.sv
hw/rv_idu.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_lsu.sv
hw/rv_ctrl.sv
hw/rv_core.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// ==== testbench/tb_programs.svh ====
// tb_programs: instruction encoders, test programs and expected store lists for rv_core
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam logic [63:0] DBASE = 64'hFFFF_FFFF_8000_1000;  // lui x10, 0x80001 sign-extends
localparam logic [31:0] EBREAK = 32'h0010_0073;

function automatic logic [31:0] r_ins(opcode_e op, logic [2:0] f3, logic [6:0] f7,
                                      logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] i_ins(opcode_e op, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] s_ins(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] b_ins(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                      logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] u_ins(opcode_e op, logic [4:0] rd, logic [19:0] imm);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] j_ins(logic [4:0] rd, logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

function automatic logic [63:0] sext32(logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

function automatic void emit(logic [31:0] inst);
  prog.push_back(inst);
endfunction

function automatic logic [63:0] here();
  return RESET_PC + 64'(4 * prog.size());
endfunction

function automatic void expect_store(int off, logic [63:0] wdata, logic [7:0] wstrb);
  exp_log.push_back(mem_req_t'{addr: DBASE + 64'(off), wdata: wdata, wstrb: wstrb, we: 1'b1});
endfunction

// sd rs, off(x10) with its expected request
function automatic void store_dword(logic [4:0] rs, int off, logic [63:0] val);
  emit(s_ins(3'b011, rs, 10, 12'(off)));
  expect_store(off, val, 8'hff);
endfunction

function automatic void build_int_ops();
  logic [63:0] pc_auipc;
  emit(u_ins(OP_LUI, 10, 20'h80001));
  emit(u_ins(OP_LUI, 1, 20'h12345));
  store_dword(1, 0, 64'h1234_5000);
  pc_auipc = here();
  emit(u_ins(OP_AUIPC, 2, 20'h00001));
  store_dword(2, 8, pc_auipc + 64'h1000);
  emit(i_ins(OP_IMM, 3'b000, 3, 0, -12'sd5));
  store_dword(3, 16, 64'(-5));
  emit(i_ins(OP_IMM, 3'b000, 4, 0, 12'd100));
  emit(r_ins(OP_REG, 3'b000, 7'h00, 5, 3, 4));  // add
  store_dword(5, 24, 64'd95);
  emit(r_ins(OP_REG, 3'b000, 7'h20, 6, 3, 4));  // sub
  store_dword(6, 32, 64'(-105));
  emit(r_ins(OP_REG, 3'b110, 7'h00, 7, 1, 4));  // or
  store_dword(7, 40, 64'h1234_5000 | 64'd100);
  emit(i_ins(OP_IMM, 3'b011, 8, 3, 12'd1));  // -5 is huge unsigned
  store_dword(8, 48, 64'd0);
  emit(i_ins(OP_IMM, 3'b011, 9, 4, 12'd101));
  store_dword(9, 56, 64'd1);
  emit(i_ins(OP_IMM, 3'b001, 11, 3, 12'd33));  // slli
  store_dword(11, 64, 64'(-5) << 33);
  emit(EBREAK);
endfunction

function automatic void build_word_ops();
  emit(u_ins(OP_LUI, 10, 20'h80001));
  emit(i_ins(OP_IMM, 3'b000, 1, 0, -12'sd1));
  emit(u_ins(OP_LUI, 2, 20'h7ffff));
  emit(i_ins(OP_IMM, 3'b000, 2, 2, 12'h7ff));  // x2 = 0x7ffff7ff
  emit(i_ins(OP_IMM32, 3'b000, 3, 2, 12'h7ff));
  store_dword(3, 0, sext32(32'h7fff_f7ff + 32'h7ff));
  emit(r_ins(OP_REG32, 3'b000, 7'h00, 4, 2, 2));  // addw wraps negative
  store_dword(4, 8, sext32(32'h7fff_f7ff + 32'h7fff_f7ff));
  emit(r_ins(OP_REG32, 3'b000, 7'h01, 5, 2, 1));
  store_dword(5, 16, sext32(32'h7fff_f7ff * 32'hffff_ffff));
  emit(r_ins(OP_REG32, 3'b100, 7'h01, 6, 2, 0));  // divide by zero
  store_dword(6, 24, 64'hffff_ffff_ffff_ffff);
  emit(r_ins(OP_REG32, 3'b110, 7'h01, 7, 2, 0));
  store_dword(7, 32, sext32(32'h7fff_f7ff));
  emit(u_ins(OP_LUI, 8, 20'h80000));
  emit(r_ins(OP_REG32, 3'b100, 7'h01, 9, 8, 1));  // overflow
  store_dword(9, 40, sext32(32'h8000_0000));
  emit(r_ins(OP_REG32, 3'b110, 7'h01, 11, 8, 1));
  store_dword(11, 48, 64'd0);
  emit(i_ins(OP_IMM, 3'b000, 12, 0, -12'sd7));
  emit(i_ins(OP_IMM, 3'b000, 13, 0, 12'd2));
  emit(r_ins(OP_REG32, 3'b100, 7'h01, 14, 12, 13));
  store_dword(14, 56, 64'(-3));  // rounds toward zero
  emit(r_ins(OP_REG32, 3'b110, 7'h01, 15, 12, 13));
  store_dword(15, 64, 64'(-1));
  emit(EBREAK);
endfunction

function automatic void build_memory();
  emit(u_ins(OP_LUI, 10, 20'h80001));
  emit(u_ins(OP_LUI, 1, 20'h87654));
  emit(i_ins(OP_IMM, 3'b000, 1, 1, 12'h321));  // x1 = sext 0x87654321
  emit(i_ins(OP_IMM, 3'b000, 2, 0, -12'sd128));
  emit(s_ins(3'b000, 2, 10, 12'd3));  // sb
  expect_store(3, 64'h0000_0000_8000_0000, 8'h08);
  emit(s_ins(3'b001, 2, 10, 12'd6));  // sh
  expect_store(6, 64'hff80_0000_0000_0000, 8'hc0);
  emit(s_ins(3'b010, 1, 10, 12'd12));  // sw
  expect_store(12, 64'h8765_4321_0000_0000, 8'hf0);
  emit(i_ins(OP_LOAD, 3'b100, 3, 10, 12'd3));
  store_dword(3, 32, 64'h80);
  emit(i_ins(OP_LOAD, 3'b001, 4, 10, 12'd6));
  store_dword(4, 40, 64'(-128));
  emit(i_ins(OP_LOAD, 3'b101, 5, 10, 12'd6));
  store_dword(5, 48, 64'hff80);
  emit(i_ins(OP_LOAD, 3'b010, 6, 10, 12'd12));
  store_dword(6, 56, sext32(32'h8765_4321));
  emit(i_ins(OP_LOAD, 3'b011, 7, 10, 12'd8));
  store_dword(7, 64, 64'h8765_4321_0000_0000);
  emit(EBREAK);
endfunction

// marker x20 stores must be skipped, x1 stores must land
function automatic void build_control();
  logic [63:0] pc_jal, pc_auipc;
  emit(u_ins(OP_LUI, 10, 20'h80001));
  emit(i_ins(OP_IMM, 3'b000, 1, 0, 12'd1));
  emit(i_ins(OP_IMM, 3'b000, 2, 0, 12'd2));
  emit(i_ins(OP_IMM, 3'b000, 20, 0, 12'h55));
  emit(i_ins(OP_IMM, 3'b000, 3, 0, -12'sd1));
  emit(b_ins(3'b000, 1, 1, 13'd8));
  emit(s_ins(3'b011, 20, 10, 12'd0));
  emit(b_ins(3'b000, 1, 2, 13'd8));
  store_dword(1, 8, 64'd1);
  emit(b_ins(3'b001, 1, 2, 13'd8));
  emit(s_ins(3'b011, 20, 10, 12'd16));
  emit(b_ins(3'b001, 1, 1, 13'd8));
  store_dword(1, 24, 64'd1);
  emit(b_ins(3'b110, 1, 2, 13'd8));
  emit(s_ins(3'b011, 20, 10, 12'd32));
  emit(b_ins(3'b110, 2, 1, 13'd8));
  store_dword(1, 40, 64'd1);
  emit(b_ins(3'b111, 2, 1, 13'd8));
  emit(s_ins(3'b011, 20, 10, 12'd48));
  emit(b_ins(3'b111, 1, 2, 13'd8));
  store_dword(1, 56, 64'd1);
  emit(b_ins(3'b110, 1, 3, 13'd8));  // 1 < all ones unsigned
  emit(s_ins(3'b011, 20, 10, 12'd64));
  pc_jal = here();
  emit(j_ins(5, 21'd8));
  emit(s_ins(3'b011, 20, 10, 12'd72));
  store_dword(5, 80, pc_jal + 64'd4);
  pc_auipc = here();
  emit(u_ins(OP_AUIPC, 6, 20'h0));
  emit(i_ins(OP_JALR, 3'b000, 7, 6, 12'd17));  // bit 0 dropped
  emit(s_ins(3'b011, 20, 10, 12'd88));
  emit(s_ins(3'b011, 20, 10, 12'd96));
  store_dword(7, 104, pc_auipc + 64'd8);
  emit(EBREAK);
endfunction

`endif

// ==== testbench/tb_rv_core.sv ====
// tb_rv_core: directed testbench for the rv_core with a behavioral shared memory
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  logic            clk, rst, mem_ready, mem_rvalid;
  logic [63:0]     mem_rdata;
  logic            o_mem_valid, o_halt, o_illegal;
  mem_req_t        o_mem_req;

  logic [63:0] mem [1024];
  logic [63:0] resp_q[$];
  logic [31:0] prog[$];
  mem_req_t    exp_log[$];
  mem_req_t    store_log[$];
  logic [31:0] seed = 32'h0bc6c88e;
  logic [9:0]  idx;
  logic        live;
  bit          random_mode;
  int          resp_wait, accept_cnt, errors, failed_tests, test_count;
  longint      cycles, limit;

  `include "tb_programs.svh"

  rv_core dut_i (
    .i_clk        (clk),
    .i_rst        (rst),
    .o_mem_valid  (o_mem_valid),
    .i_mem_ready  (mem_ready),
    .o_mem_req    (o_mem_req),
    .i_mem_rvalid (mem_rvalid),
    .i_mem_rdata  (mem_rdata),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // memory model, one request and one response in flight
  always @(posedge clk) begin
    live = !rst;
    if (rst) begin
      resp_q.delete();
      resp_wait = 0;
    end else begin
      if (mem_rvalid) void'(resp_q.pop_front());
      if (o_mem_valid && mem_ready) begin
        idx = o_mem_req.addr[12:3];
        if (o_mem_req.we) begin
          for (int b = 0; b < 8; b++) begin
            if (o_mem_req.wstrb[b]) mem[idx][8*b +: 8] = o_mem_req.wdata[8*b +: 8];
          end
          store_log.push_back(o_mem_req);
        end
        resp_q.push_back(mem[idx]);
        resp_wait = random_mode ? int'((lcg_next() >> 12) % 4) : 0;
        accept_cnt++;
      end
    end
    #1;
    mem_ready = random_mode ? ((lcg_next() >> 8) % 4 != 0) : 1'b1;
    if (live && resp_q.size() > 0 && resp_wait == 0) begin
      mem_rvalid = 1'b1;
      mem_rdata  = resp_q[0];
    end else begin
      mem_rvalid = 1'b0;
      if (resp_wait > 0) resp_wait--;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the core never stopped", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check_store(input string name, input mem_req_t got, input mem_req_t exp);
    logic [63:0] lanes;
    for (int b = 0; b < 8; b++) lanes[8*b +: 8] = {8{exp.wstrb[b]}};
    // bytes outside the strobes carry no data
    if (got.addr !== exp.addr || got.wstrb !== exp.wstrb || got.we !== exp.we ||
        (got.wdata & lanes) !== (exp.wdata & lanes)) begin
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic void build_program(int id);
    prog.delete();
    exp_log.delete();
    case (id)
      0: build_int_ops();
      1: build_word_ops();
      2: build_memory();
      3: build_control();
      4: begin
        emit(u_ins(OP_LUI, 10, 20'h80001));
        emit(EBREAK);
        emit(s_ins(3'b011, 0, 10, 12'd0));  // never reached
      end
      default: begin
        emit(i_ins(OP_IMM, 3'b000, 1, 0, 12'd7));
        emit(32'h0000_007f);  // unknown opcode
      end
    endcase
  endfunction

  task automatic run_program(input string name, input bit rnd, input logic exp_halt,
                             input logic exp_illegal);
    int err0;
    int acc_at_stop;
    err0 = errors;
    for (int i = 0; i < 1024; i++) mem[i] = '0;
    for (int i = 0; i < prog.size(); i++) mem[i/2][(i%2)*32 +: 32] = prog[i];
    store_log.delete();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (8) @(posedge clk);
    random_mode = rnd;
    #1 rst = 1'b0;
    while (!(o_halt || o_illegal)) begin
      @(posedge clk);
      #1;
    end
    acc_at_stop = accept_cnt;
    repeat (20) @(posedge clk);  // watch for stray requests
    #1;
    check_flag({name, ".o_halt"}, o_halt, exp_halt);
    check_flag({name, ".o_illegal"}, o_illegal, exp_illegal);
    check_flag({name, ".o_mem_valid"}, o_mem_valid, 1'b0);
    if (accept_cnt != acc_at_stop) begin
      $display("%s: memory requests issued after the core stopped", name);
      errors++;
    end
    if (store_log.size() != exp_log.size()) begin
      $display("%s: %0d stores seen, %0d expected", name, store_log.size(), exp_log.size());
      errors++;
    end else begin
      foreach (exp_log[i]) check_store($sformatf("%s.o_mem_req[%0d]", name, i), store_log[i],
                                       exp_log[i]);
    end
    test_count++;
    if (errors != err0) failed_tests++;
    $display("test %-16s %s", name, (errors == err0) ? "pass" : "fail");
  endtask

  initial begin
    string names [4];
    longint total;
    rst = 1'b1;
    mem_ready = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    random_mode = 1'b0;
    names = '{"int_ops", "word_ops", "memory", "control"};
    total = 0;
    for (int id = 0; id < 6; id++) begin
      build_program(id);
      total += (id < 4) ? 2 * prog.size() : prog.size();
    end
    limit = total * 12 + 10 * (8 + 20 + 2);  // ten runs, reset and watch window each
    for (int id = 0; id < 4; id++) begin
      build_program(id);
      run_program(names[id], 1'b0, 1'b1, 1'b0);
    end
    for (int id = 0; id < 4; id++) begin
      build_program(id);
      run_program({names[id], "_bp"}, 1'b1, 1'b1, 1'b0);
    end
    build_program(4);
    run_program("ebreak", 1'b0, 1'b1, 1'b0);
    build_program(5);
    run_program("illegal", 1'b0, 1'b0, 1'b1);
    $display("tests run %0d, failed %0d, check errors %0d", test_count, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/rv_core.sv ====
// rv_core: top level of the multi-cycle RV64 core with one shared memory port
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  output logic            o_mem_valid,
  input  logic            i_mem_ready,
  output mem_req_t        o_mem_req,
  input  logic            i_mem_rvalid,
  input  logic [XLEN-1:0] i_mem_rdata,
  output logic            o_halt,
  output logic            o_illegal
);

  decode_t         dec;
  mem_req_t        data_req;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc, rs1, rs2, op_a, op_b, alu_result, load_data, wr_data;
  logic            zero, less_u, wr_en;

  assign op_a = dec.asrc_pc ? pc : rs1;

  always_comb begin
    case (dec.bsrc)
      BSRC_IMM:  op_b = dec.imm;
      BSRC_FOUR: op_b = XLEN'(4);
      default:   op_b = rs2;
    endcase
  end

  rv_ctrl ctrl_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_dec        (dec),
    .i_rs1        (rs1),
    .i_alu_result (alu_result),
    .i_zero       (zero),
    .i_less_u     (less_u),
    .i_load_data  (load_data),
    .i_data_req   (data_req),
    .i_mem_ready  (i_mem_ready),
    .i_mem_rvalid (i_mem_rvalid),
    .i_mem_rdata  (i_mem_rdata),
    .o_inst       (inst),
    .o_pc         (pc),
    .o_mem_valid  (o_mem_valid),
    .o_mem_req    (o_mem_req),
    .o_wr_en      (wr_en),
    .o_wr_data    (wr_data),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

  rv_idu idu_i (
    .i_inst (inst),
    .o_dec  (dec)
  );

  rv_alu alu_i (
    .i_a        (op_a),
    .i_b        (op_b),
    .i_op       (dec.alu_op),
    .i_word_cut (dec.word_cut),
    .o_result   (alu_result),
    .o_zero     (zero),
    .o_less_u   (less_u)
  );

  rv_regfile regfile_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_ra      (dec.ra),
    .i_rb      (dec.rb),
    .i_rd      (dec.rd),
    .i_wr_en   (wr_en),
    .i_wr_data (wr_data),
    .o_rs1     (rs1),
    .o_rs2     (rs2)
  );

  rv_lsu lsu_i (
    .i_addr      (alu_result),
    .i_rs2       (rs2),
    .i_mem_op    (dec.mem_op),
    .i_mem_wr    (dec.mem_wr),
    .i_rdata     (i_mem_rdata),
    .o_req       (data_req),
    .o_load_data (load_data)
  );

endmodule

// ==== hw/rv_ctrl.sv ====
// rv_ctrl: multi-cycle control FSM with pc, instruction register and memory port mux
`timescale 1ns/1ps

module rv_ctrl
  import rv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  input  decode_t         i_dec,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_alu_result,
  input  logic            i_zero,
  input  logic            i_less_u,
  input  logic [XLEN-1:0] i_load_data,
  input  mem_req_t        i_data_req,
  input  logic            i_mem_ready,
  input  logic            i_mem_rvalid,
  input  logic [XLEN-1:0] i_mem_rdata,
  output logic [31:0]     o_inst,
  output logic [XLEN-1:0] o_pc,
  output logic            o_mem_valid,
  output mem_req_t        o_mem_req,
  output logic            o_wr_en,
  output logic [XLEN-1:0] o_wr_data,
  output logic            o_halt,
  output logic            o_illegal
);

  state_e          state;
  logic [XLEN-1:0] next_pc, jalr_sum;
  logic            taken, is_mem, exec_done, mem_done;

  always_comb begin
    case (i_dec.branch)
      BR_JAL:  taken = 1'b1;
      BR_EQ:   taken = i_zero;
      BR_NE:   taken = ~i_zero;
      BR_LTU:  taken = i_less_u;
      BR_GEU:  taken = ~i_less_u;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1 + i_dec.imm;
  assign next_pc  = (i_dec.branch == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} :
                    taken ? (o_pc + i_dec.imm) : (o_pc + XLEN'(4));

  assign is_mem    = i_dec.mem_to_reg | i_dec.mem_wr;
  assign exec_done = (state == ST_EXEC) && !is_mem;
  assign mem_done  = (state == ST_MEM_WAIT) && i_mem_rvalid;
  assign o_wr_en   = (exec_done && i_dec.reg_wr) || (mem_done && i_dec.mem_to_reg);
  assign o_wr_data = i_dec.mem_to_reg ? i_load_data : i_alu_result;

  assign o_mem_req = (state == ST_MEM) ? i_data_req :
                     mem_req_t'{addr: o_pc, wdata: '0, wstrb: 8'h00, we: 1'b0};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= ST_FETCH;
      o_pc        <= RESET_PC;
      o_inst      <= NOP_INST;
      o_mem_valid <= 1'b0;
      o_halt      <= 1'b0;
      o_illegal   <= 1'b0;
    end else begin
      case (state)
        ST_FETCH: begin
          o_mem_valid <= 1'b1;  // first raise after reset
          if (o_mem_valid && i_mem_ready) begin
            o_mem_valid <= 1'b0;
            state       <= ST_FETCH_WAIT;
          end
        end
        ST_FETCH_WAIT: begin
          if (i_mem_rvalid) begin
            o_inst <= o_pc[2] ? i_mem_rdata[63:32] : i_mem_rdata[31:0];
            state  <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (i_dec.illegal) begin
            o_illegal <= 1'b1;
            state     <= ST_STOP;
          end else if (i_dec.halt) begin
            o_halt <= 1'b1;
            state  <= ST_STOP;
          end else if (is_mem) begin
            o_mem_valid <= 1'b1;
            state       <= ST_MEM;
          end else begin
            o_pc        <= next_pc;
            o_inst      <= NOP_INST;
            o_mem_valid <= 1'b1;
            state       <= ST_FETCH;
          end
        end
        ST_MEM: begin
          if (i_mem_ready) begin
            o_mem_valid <= 1'b0;
            state       <= ST_MEM_WAIT;
          end
        end
        ST_MEM_WAIT: begin
          if (i_mem_rvalid) begin
            o_pc        <= next_pc;
            o_inst      <= NOP_INST;
            o_mem_valid <= 1'b1;
            state       <= ST_FETCH;
          end
        end
        default: state <= ST_STOP;  // halted until reset
      endcase
    end
  end

  a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_mem_valid && !i_mem_ready) |=> (o_mem_valid && $stable(o_mem_req)));

  a_rvalid_wait: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mem_rvalid |-> (state inside {ST_FETCH_WAIT, ST_MEM_WAIT}));

endmodule

// ==== hw/rv_lsu.sv ====
// rv_lsu: data request builder with byte lanes and strobes, load extract and extend
`timescale 1ns/1ps

module rv_lsu
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_rs2,
  input  mem_op_e         i_mem_op,
  input  logic            i_mem_wr,
  input  logic [XLEN-1:0] i_rdata,
  output mem_req_t        o_req,
  output logic [XLEN-1:0] o_load_data
);

  logic [2:0]      lane;
  logic [5:0]      shamt;
  logic [7:0]      size_mask, wstrb;
  logic [XLEN-1:0] rshift;
  logic            aligned;

  assign lane  = i_addr[2:0];
  assign shamt = {lane, 3'b000};

  always_comb begin
    case (i_mem_op)
      MEM_B, MEM_BU: begin
        size_mask = 8'h01;
        aligned   = 1'b1;
      end
      MEM_H, MEM_HU: begin
        size_mask = 8'h03;
        aligned   = ~lane[0];
      end
      MEM_W, MEM_WU: begin
        size_mask = 8'h0f;
        aligned   = (lane[1:0] == 2'b00);
      end
      MEM_D: begin
        size_mask = 8'hff;
        aligned   = (lane == 3'b000);
      end
      default: begin
        size_mask = 8'h00;
        aligned   = 1'b1;
      end
    endcase
  end

  assign wstrb = i_mem_wr ? (size_mask << lane) : 8'h00;
  assign o_req = '{addr: i_addr, wdata: i_rs2 << shamt, wstrb: wstrb, we: i_mem_wr};

  assign rshift = i_rdata >> shamt;  // addressed byte to lane 0

  always_comb begin
    case (i_mem_op)
      MEM_B:   o_load_data = {{56{rshift[7]}}, rshift[7:0]};
      MEM_BU:  o_load_data = {56'b0, rshift[7:0]};
      MEM_H:   o_load_data = {{48{rshift[15]}}, rshift[15:0]};
      MEM_HU:  o_load_data = {48'b0, rshift[15:0]};
      MEM_W:   o_load_data = {{32{rshift[31]}}, rshift[31:0]};
      MEM_WU:  o_load_data = {32'b0, rshift[31:0]};
      default: o_load_data = rshift;
    endcase
  end

  // the control unit parks a nop between instructions, so only live accesses get here
  always_comb begin
    if (i_mem_op != MEM_NONE) begin
      a_aligned: assert final (aligned);
    end
  end

endmodule

// ==== hw/rv_regfile.sv ====
// rv_regfile: 32 x 64-bit integer registers, two read ports, x0 reads zero
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [4:0]      i_ra,
  input  logic [4:0]      i_rb,
  input  logic [4:0]      i_rd,
  input  logic            i_wr_en,
  input  logic [XLEN-1:0] i_wr_data,
  output logic [XLEN-1:0] o_rs1,
  output logic [XLEN-1:0] o_rs2
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      regs[0] <= '0;  // x0 cleared here, never written
    end else if (i_wr_en && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wr_data;
    end
  end

  assign o_rs1 = regs[i_ra];
  assign o_rs2 = regs[i_rb];

  a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst)
    ((i_ra == 5'd0) |-> (o_rs1 == '0)) and ((i_rb == 5'd0) |-> (o_rs2 == '0)));

endmodule

// ==== hw/rv_alu.sv ====
// rv_alu: 64-bit integer ALU with word mode, mul/div/rem and branch compare flags
`timescale 1ns/1ps

module rv_alu
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  alu_op_e         i_op,
  input  logic            i_word_cut,
  output logic [XLEN-1:0] o_result,
  output logic            o_zero,
  output logic            o_less_u
);

  logic [XLEN-1:0] a, b, raw, quot, rem;
  logic            div_zero, div_ovf;

  // word ops see sign-extended low halves
  assign a = i_word_cut ? {{32{i_a[31]}}, i_a[31:0]} : i_a;
  assign b = i_word_cut ? {{32{i_b[31]}}, i_b[31:0]} : i_b;

  assign div_zero = (b == '0);
  assign div_ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);

  always_comb begin
    if (div_zero) begin
      quot = '1;
      rem  = a;
    end else if (div_ovf) begin
      quot = a;
      rem  = '0;
    end else begin
      quot = $signed(a) / $signed(b);
      rem  = $signed(a) % $signed(b);
    end
  end

  always_comb begin
    case (i_op)
      ALU_ADD:    raw = a + b;
      ALU_SUB:    raw = a - b;
      ALU_SLTU:   raw = {{(XLEN-1){1'b0}}, a < b};
      ALU_OR:     raw = a | b;
      ALU_SLL:    raw = a << b[5:0];
      ALU_COPY_B: raw = b;
      ALU_MUL:    raw = a * b;  // low bits only
      ALU_DIV:    raw = quot;
      ALU_REM:    raw = rem;
      default:    raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;
  assign o_zero   = (a == b);
  assign o_less_u = (a < b);

endmodule

// ==== hw/rv_idu.sv ====
// rv_idu: combinational RV64 instruction decoder, builds control fields and immediate
`timescale 1ns/1ps

module rv_idu
  import rv_pkg::*;
(
  input  logic [31:0] i_inst,
  output decode_t     o_dec
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_u, imm_s, imm_b, imm_j, imm_sel;
  alu_op_e         alu_op;
  branch_e         branch;
  mem_op_e         mem_op;
  bsrc_e           bsrc;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  wire inst_lui    = (opcode == OP_LUI);
  wire inst_auipc  = (opcode == OP_AUIPC);
  wire inst_jal    = (opcode == OP_JAL);
  wire inst_jalr   = (opcode == OP_JALR) && (funct3 == 3'b000);
  wire inst_beq    = (opcode == OP_BRANCH) && (funct3 == 3'b000);
  wire inst_bne    = (opcode == OP_BRANCH) && (funct3 == 3'b001);
  wire inst_bltu   = (opcode == OP_BRANCH) && (funct3 == 3'b110);
  wire inst_bgeu   = (opcode == OP_BRANCH) && (funct3 == 3'b111);
  wire inst_lh     = (opcode == OP_LOAD) && (funct3 == 3'b001);
  wire inst_lw     = (opcode == OP_LOAD) && (funct3 == 3'b010);
  wire inst_ld     = (opcode == OP_LOAD) && (funct3 == 3'b011);
  wire inst_lbu    = (opcode == OP_LOAD) && (funct3 == 3'b100);
  wire inst_lhu    = (opcode == OP_LOAD) && (funct3 == 3'b101);
  wire inst_sb     = (opcode == OP_STORE) && (funct3 == 3'b000);
  wire inst_sh     = (opcode == OP_STORE) && (funct3 == 3'b001);
  wire inst_sw     = (opcode == OP_STORE) && (funct3 == 3'b010);
  wire inst_sd     = (opcode == OP_STORE) && (funct3 == 3'b011);
  wire inst_addi   = (opcode == OP_IMM) && (funct3 == 3'b000);
  wire inst_slli   = (opcode == OP_IMM) && (funct3 == 3'b001) && (funct7[6:1] == 6'b0);
  wire inst_sltiu  = (opcode == OP_IMM) && (funct3 == 3'b011);
  wire inst_add    = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  wire inst_sub    = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  wire inst_or     = (opcode == OP_REG) && (funct3 == 3'b110) && (funct7 == 7'b0000000);
  wire inst_addiw  = (opcode == OP_IMM32) && (funct3 == 3'b000);
  wire inst_addw   = (opcode == OP_REG32) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  wire inst_mulw   = (opcode == OP_REG32) && (funct3 == 3'b000) && (funct7 == 7'b0000001);
  wire inst_divw   = (opcode == OP_REG32) && (funct3 == 3'b100) && (funct7 == 7'b0000001);
  wire inst_remw   = (opcode == OP_REG32) && (funct3 == 3'b110) && (funct7 == 7'b0000001);
  wire inst_ebreak = (opcode == OP_SYSTEM) && (i_inst[31:7] == 25'h0002000);

  wire inst_load = |{inst_lh, inst_lhu, inst_lw, inst_lbu, inst_ld};
  wire type_r    = |{inst_add, inst_sub, inst_or, inst_addw, inst_mulw, inst_divw, inst_remw};
  wire type_i    = |{inst_jalr, inst_load, inst_addi, inst_sltiu, inst_slli, inst_addiw};
  wire type_u    = inst_lui | inst_auipc;
  wire type_s    = |{inst_sb, inst_sh, inst_sw, inst_sd};
  wire type_b    = |{inst_beq, inst_bne, inst_bltu, inst_bgeu};
  wire legal     = |{type_r, type_i, type_u, type_s, type_b, inst_jal, inst_ebreak};

  always_comb begin
    if (type_u) imm_sel = imm_u;
    else if (type_s) imm_sel = imm_s;
    else if (type_b) imm_sel = imm_b;
    else if (inst_jal) imm_sel = imm_j;
    else imm_sel = imm_i;
  end

  always_comb begin
    if (inst_lui) alu_op = ALU_COPY_B;
    else if (|{inst_auipc, inst_jal, inst_jalr, inst_addi, inst_add, inst_load, type_s,
               inst_addiw, inst_addw}) alu_op = ALU_ADD;
    else if (type_b | inst_sub) alu_op = ALU_SUB;  // branches compare through sub
    else if (inst_sltiu) alu_op = ALU_SLTU;
    else if (inst_or) alu_op = ALU_OR;
    else if (inst_slli) alu_op = ALU_SLL;
    else if (inst_mulw) alu_op = ALU_MUL;
    else if (inst_divw) alu_op = ALU_DIV;
    else if (inst_remw) alu_op = ALU_REM;
    else alu_op = ALU_NONE;
  end

  always_comb begin
    if (inst_jal) branch = BR_JAL;
    else if (inst_jalr) branch = BR_JALR;
    else if (inst_beq) branch = BR_EQ;
    else if (inst_bne) branch = BR_NE;
    else if (inst_bltu) branch = BR_LTU;
    else if (inst_bgeu) branch = BR_GEU;
    else branch = BR_NONE;
  end

  always_comb begin
    if (inst_sb) mem_op = MEM_B;
    else if (inst_lbu) mem_op = MEM_BU;
    else if (inst_sh | inst_lh) mem_op = MEM_H;
    else if (inst_lhu) mem_op = MEM_HU;
    else if (inst_sw | inst_lw) mem_op = MEM_W;
    else if (inst_sd | inst_ld) mem_op = MEM_D;
    else mem_op = MEM_NONE;
  end

  assign bsrc = (inst_jal | inst_jalr) ? BSRC_FOUR :
                (type_i | type_u | type_s) ? BSRC_IMM : BSRC_RS2;

  // unmatched encodings leave every enable low
  assign o_dec = '{
    imm:        imm_sel,
    ra:         i_inst[19:15],
    rb:         i_inst[24:20],
    rd:         i_inst[11:7],
    branch:     branch,
    asrc_pc:    inst_jal | inst_jalr | inst_auipc,
    bsrc:       bsrc,
    alu_op:     alu_op,
    word_cut:   |{inst_addiw, inst_addw, inst_mulw, inst_divw, inst_remw},
    reg_wr:     |{type_r, type_i, type_u, inst_jal},
    mem_to_reg: inst_load,
    mem_wr:     type_s,
    mem_op:     mem_op,
    halt:       inst_ebreak,
    illegal:    ~legal
  };

endmodule

// ==== hw/rv_pkg.sv ====
// rv_pkg: shared constants, enums and structs of the RV64 multi-cycle core
package rv_pkg;

  localparam int XLEN = 64;
  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;
  localparam logic [31:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_AUIPC  = 7'b0010111,
    OP_IMM32  = 7'b0011011,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_REG32  = 7'b0111011,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_COPY_B = 4'b0011,  // lui
    ALU_OR     = 4'b0110,
    ALU_SUB    = 4'b1000,
    ALU_SLTU   = 4'b1010,
    ALU_DIV    = 4'b1011,
    ALU_MUL    = 4'b1100,
    ALU_REM    = 4'b1101,
    ALU_NONE   = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } branch_e;

  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10  // link address pc+4
  } bsrc_e;

  typedef enum logic [2:0] {
    MEM_B    = 3'b000,
    MEM_BU   = 3'b001,
    MEM_H    = 3'b010,
    MEM_HU   = 3'b011,
    MEM_W    = 3'b100,
    MEM_WU   = 3'b101,
    MEM_D    = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef struct packed {
    logic [XLEN-1:0] imm;
    logic [4:0]      ra;
    logic [4:0]      rb;
    logic [4:0]      rd;
    branch_e         branch;
    logic            asrc_pc;  // operand a is the pc
    bsrc_e           bsrc;
    alu_op_e         alu_op;
    logic            word_cut;
    logic            reg_wr;
    logic            mem_to_reg;
    logic            mem_wr;
    mem_op_e         mem_op;
    logic            halt;
    logic            illegal;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [7:0]      wstrb;
    logic            we;
  } mem_req_t;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_FETCH_WAIT,
    ST_EXEC,
    ST_MEM,
    ST_MEM_WAIT,
    ST_STOP
  } state_e;

endpackage
